//--- verilog/fmul_pkg.sv
`default_nettype none

package fmul_pkg;

	// Reorder-buffer tag.
	localparam int TAG_WIDTH = 5;

	// IEEE single-precision fields.
	localparam int EXP_WIDTH = 8;
	localparam int MAN_WIDTH = 23;

	// Quiet NaN returned for every invalid product.
	localparam logic [31:0] CANON_NAN = 32'h7fc0_0000;

	// Operand slot in a station entry.
	typedef enum logic {
		OPD_WAIT,
		OPD_READY
	} entry_state_e;

endpackage

`default_nettype wire

//--- verilog/fmul_station.sv
`timescale 1ns/1ps
`default_nettype none

module fmul_station #(
	parameter int RS_DEPTH = 2
) (
	input  wire                            clk,
	input  wire                            reset,
	input  wire                            issue_valid,
	output logic                           issue_ready,
	input  wire [fmul_pkg::TAG_WIDTH-1:0]  issue_tag,
	input  wire                            opa_ready,
	input  wire [fmul_pkg::TAG_WIDTH-1:0]  opa_tag,
	input  wire [31:0]                     opa_data,
	input  wire                            opb_ready,
	input  wire [fmul_pkg::TAG_WIDTH-1:0]  opb_tag,
	input  wire [31:0]                     opb_data,
	input  wire                            cdb_in_valid,
	input  wire [fmul_pkg::TAG_WIDTH-1:0]  cdb_in_tag,
	input  wire [31:0]                     cdb_in_data,
	output logic                           disp_valid,
	input  wire                            disp_ready,
	output logic [fmul_pkg::TAG_WIDTH-1:0] disp_tag,
	output logic [31:0]                    disp_a,
	output logic [31:0]                    disp_b
);
	localparam int CNT_W = $clog2(RS_DEPTH + 1);
	localparam int SEL_W = $clog2(RS_DEPTH);

	// Entries are packed from index 0, oldest first.
	logic [RS_DEPTH-1:0]            ent_valid;
	logic [fmul_pkg::TAG_WIDTH-1:0] ent_tag [RS_DEPTH];
	fmul_pkg::entry_state_e         ent_state [RS_DEPTH][2];
	logic [fmul_pkg::TAG_WIDTH-1:0] ent_otag [RS_DEPTH][2];
	logic [31:0]                    ent_data [RS_DEPTH][2];

	fmul_pkg::entry_state_e         upd_state [RS_DEPTH][2];
	logic [31:0]                    upd_data [RS_DEPTH][2];

	fmul_pkg::entry_state_e         new_state [2];
	logic [fmul_pkg::TAG_WIDTH-1:0] new_otag [2];
	logic [31:0]                    new_data [2];
	logic                           new_rdy [2];

	logic [RS_DEPTH-1:0]            nxt_valid;
	logic [fmul_pkg::TAG_WIDTH-1:0] nxt_tag [RS_DEPTH];
	fmul_pkg::entry_state_e         nxt_state [RS_DEPTH][2];
	logic [fmul_pkg::TAG_WIDTH-1:0] nxt_otag [RS_DEPTH][2];
	logic [31:0]                    nxt_data [RS_DEPTH][2];

	logic [RS_DEPTH-1:0]            ent_rdy;
	logic [SEL_W-1:0]               sel;
	logic [CNT_W-1:0]               vld_count;
	logic [CNT_W-1:0]               cnt_after;
	logic                           dispatch;
	logic                           issue_fire;

	// Incoming instruction, woken by a same-cycle broadcast.
	assign new_otag[0] = opa_tag;
	assign new_otag[1] = opb_tag;
	assign new_rdy[0]  = opa_ready;
	assign new_rdy[1]  = opb_ready;

	always_comb begin
		for (int j = 0; j < 2; j++) begin
			if (new_rdy[j]) begin
				new_state[j] = fmul_pkg::OPD_READY;
				new_data[j]  = (j == 0) ? opa_data : opb_data;
			end else if (cdb_in_valid && cdb_in_tag == new_otag[j]) begin
				new_state[j] = fmul_pkg::OPD_READY;
				new_data[j]  = cdb_in_data;
			end else begin
				new_state[j] = fmul_pkg::OPD_WAIT;
				new_data[j]  = (j == 0) ? opa_data : opb_data;
			end
		end
	end

	// CDB snoop on held entries.
	always_comb begin
		for (int i = 0; i < RS_DEPTH; i++) begin
			for (int j = 0; j < 2; j++) begin
				if (ent_state[i][j] == fmul_pkg::OPD_WAIT && cdb_in_valid &&
						ent_otag[i][j] == cdb_in_tag) begin
					upd_state[i][j] = fmul_pkg::OPD_READY;
					upd_data[i][j]  = cdb_in_data;
				end else begin
					upd_state[i][j] = ent_state[i][j];
					upd_data[i][j]  = ent_data[i][j];
				end
			end
		end
	end

	always_comb begin
		vld_count = '0;
		for (int i = 0; i < RS_DEPTH; i++) begin
			ent_rdy[i] = ent_valid[i] && ent_state[i][0] == fmul_pkg::OPD_READY &&
				ent_state[i][1] == fmul_pkg::OPD_READY;
			vld_count = vld_count + CNT_W'(ent_valid[i]);
		end
	end

	// Lowest ready index wins.
	always_comb begin
		sel = '0;
		for (int i = RS_DEPTH - 1; i >= 0; i--) begin
			if (ent_rdy[i]) begin
				sel = SEL_W'(i);
			end
		end
	end

	assign disp_valid  = |ent_rdy;
	assign disp_tag    = ent_tag[sel];
	assign disp_a      = ent_data[sel][0];
	assign disp_b      = ent_data[sel][1];
	assign dispatch    = disp_valid && disp_ready;
	assign issue_ready = !ent_valid[RS_DEPTH-1] || dispatch;
	assign issue_fire  = issue_valid && issue_ready;

	// Shift down above the sent entry, then append.
	always_comb begin
		int src;
		cnt_after = vld_count - CNT_W'(dispatch);
		for (int i = 0; i < RS_DEPTH; i++) begin
			src = i;
			if (dispatch && i >= int'(sel) && i < RS_DEPTH - 1) begin
				src = i + 1;
			end
			nxt_valid[i] = 1'b0;
			nxt_tag[i]   = ent_tag[i];
			for (int j = 0; j < 2; j++) begin
				nxt_state[i][j] = ent_state[i][j];
				nxt_otag[i][j]  = ent_otag[i][j];
				nxt_data[i][j]  = ent_data[i][j];
			end
			if (CNT_W'(i) < cnt_after) begin
				nxt_valid[i] = 1'b1;
				nxt_tag[i]   = ent_tag[src];
				for (int j = 0; j < 2; j++) begin
					nxt_state[i][j] = upd_state[src][j];
					nxt_otag[i][j]  = ent_otag[src][j];
					nxt_data[i][j]  = upd_data[src][j];
				end
			end else if (CNT_W'(i) == cnt_after && issue_fire) begin
				nxt_valid[i] = 1'b1;
				nxt_tag[i]   = issue_tag;
				for (int j = 0; j < 2; j++) begin
					nxt_state[i][j] = new_state[j];
					nxt_otag[i][j]  = new_otag[j];
					nxt_data[i][j]  = new_data[j];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ent_valid <= '0;
		end else begin
			ent_valid <= nxt_valid;
		end
	end

	always_ff @(posedge clk) begin
		ent_tag   <= nxt_tag;
		ent_state <= nxt_state;
		ent_otag  <= nxt_otag;
		ent_data  <= nxt_data;
	end

	// A full station that cannot dispatch keeps its occupancy.
	a_no_overfill: assert property (@(posedge clk) disable iff (reset)
		issue_valid && !issue_ready |=> vld_count == $past(vld_count));

	a_contiguous: assert property (@(posedge clk) disable iff (reset)
		(ent_valid & (ent_valid + 1'b1)) == '0);

endmodule

`default_nettype wire

//--- verilog/fmul_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module fmul_pipe (
	input  wire                            clk,
	input  wire                            reset,
	input  wire                            disp_valid,
	output logic                           disp_ready,
	input  wire [fmul_pkg::TAG_WIDTH-1:0]  disp_tag,
	input  wire [31:0]                     disp_a,
	input  wire [31:0]                     disp_b,
	output logic                           prod_valid,
	input  wire                            prod_ready,
	output logic [fmul_pkg::TAG_WIDTH-1:0] prod_tag,
	output logic [31:0]                    prod_data
);
	localparam int EW = fmul_pkg::EXP_WIDTH;
	localparam int MW = fmul_pkg::MAN_WIDTH;
	localparam int PW = 2 * (MW + 1);
	localparam logic [EW-1:0]          EXP_ALL1 = {EW{1'b1}};
	localparam logic signed [EW+1:0] BIAS     = (1 << (EW - 1)) - 1;
	localparam logic signed [EW+1:0] EXP_ONE  = 1;
	localparam logic signed [EW+1:0] EXP_ZERO = 0;
	localparam logic signed [EW+1:0] EXP_MAX  = (1 << EW) - 1;

	logic                           advance;

	logic [EW-1:0]                  exp_a, exp_b;
	logic [MW-1:0]                  frac_a, frac_b;
	logic                           nan_a, nan_b, inf_a, inf_b, zero_a, zero_b;

	logic                           s1_valid;
	logic [fmul_pkg::TAG_WIDTH-1:0] s1_tag;
	logic                           s1_sign;
	logic signed [EW+1:0]           s1_exp;
	logic [MW:0]                    s1_ma, s1_mb;
	logic                           s1_nan, s1_inf, s1_zero;

	logic                           s2_valid;
	logic [fmul_pkg::TAG_WIDTH-1:0] s2_tag;
	logic                           s2_sign;
	logic signed [EW+1:0]           s2_exp;
	logic [PW-1:0]                  s2_prod;
	logic                           s2_nan, s2_inf, s2_zero;

	logic [MW-1:0]                  norm_man;
	logic signed [EW+1:0]           norm_exp;
	logic                           guard, sticky, round_up;
	logic [MW:0]                    rnd_man;
	logic signed [EW+1:0]           rnd_exp;
	logic [31:0]                    result;

	// Whole pipe freezes on a blocked output.
	assign advance    = !prod_valid || prod_ready;
	assign disp_ready = advance;

	assign exp_a  = disp_a[MW +: EW];
	assign exp_b  = disp_b[MW +: EW];
	assign frac_a = disp_a[MW-1:0];
	assign frac_b = disp_b[MW-1:0];
	assign nan_a  = exp_a == EXP_ALL1 && frac_a != '0;
	assign nan_b  = exp_b == EXP_ALL1 && frac_b != '0;
	assign inf_a  = exp_a == EXP_ALL1 && frac_a == '0;
	assign inf_b  = exp_b == EXP_ALL1 && frac_b == '0;
	// Denormals count as zero.
	assign zero_a = exp_a == '0;
	assign zero_b = exp_b == '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid   <= 1'b0;
			s2_valid   <= 1'b0;
			prod_valid <= 1'b0;
		end else if (advance) begin
			s1_valid   <= disp_valid;
			s2_valid   <= s1_valid;
			prod_valid <= s2_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			s1_tag  <= disp_tag;
			s1_sign <= disp_a[31] ^ disp_b[31];
			s1_exp  <= $signed({2'b00, exp_a}) + $signed({2'b00, exp_b}) - BIAS;
			s1_ma   <= {1'b1, frac_a};
			s1_mb   <= {1'b1, frac_b};
			s1_nan  <= nan_a || nan_b || (inf_a && zero_b) || (inf_b && zero_a);
			s1_inf  <= inf_a || inf_b;
			s1_zero <= zero_a || zero_b;

			s2_tag  <= s1_tag;
			s2_sign <= s1_sign;
			s2_exp  <= s1_exp;
			s2_prod <= s1_ma * s1_mb;
			s2_nan  <= s1_nan;
			s2_inf  <= s1_inf;
			s2_zero <= s1_zero;

			prod_tag  <= s2_tag;
			prod_data <= result;
		end
	end

	// Normalise, then round to nearest even.
	always_comb begin
		if (s2_prod[PW-1]) begin
			norm_man = s2_prod[PW-2 -: MW];
			guard    = s2_prod[PW-2-MW];
			sticky   = |s2_prod[PW-3-MW:0];
			norm_exp = s2_exp + EXP_ONE;
		end else begin
			norm_man = s2_prod[PW-3 -: MW];
			guard    = s2_prod[PW-3-MW];
			sticky   = |s2_prod[PW-4-MW:0];
			norm_exp = s2_exp;
		end
		round_up = guard && (sticky || norm_man[0]);
		rnd_man  = {1'b0, norm_man} + (MW + 1)'(round_up);
		// Mantissa carry bumps the exponent.
		rnd_exp  = rnd_man[MW] ? norm_exp + EXP_ONE : norm_exp;

		if (s2_nan) begin
			result = fmul_pkg::CANON_NAN;
		end else if (s2_inf || rnd_exp >= EXP_MAX) begin
			result = {s2_sign, EXP_ALL1, {MW{1'b0}}};
		end else if (s2_zero || rnd_exp <= EXP_ZERO) begin
			result = {s2_sign, {(EW + MW){1'b0}}};
		end else begin
			result = {s2_sign, rnd_exp[EW-1:0], rnd_man[MW-1:0]};
		end
	end

	a_prod_hold: assert property (@(posedge clk) disable iff (reset)
		prod_valid && !prod_ready |=>
			prod_valid && $stable(prod_tag) && $stable(prod_data));

endmodule

`default_nettype wire

//--- verilog/fmul_result_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module fmul_result_buffer #(
	parameter int RESULT_DEPTH = 2
) (
	input  wire                            clk,
	input  wire                            reset,
	input  wire                            prod_valid,
	output logic                           prod_ready,
	input  wire [fmul_pkg::TAG_WIDTH-1:0]  prod_tag,
	input  wire [31:0]                     prod_data,
	output logic                           res_valid,
	input  wire                            res_ready,
	output logic [fmul_pkg::TAG_WIDTH-1:0] res_tag,
	output logic [31:0]                    res_data
);
	localparam int PTR_W = $clog2(RESULT_DEPTH);
	localparam int CNT_W = $clog2(RESULT_DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST = PTR_W'(RESULT_DEPTH - 1);
	localparam logic [CNT_W-1:0] FULL = CNT_W'(RESULT_DEPTH);

	logic [fmul_pkg::TAG_WIDTH-1:0] mem_tag [RESULT_DEPTH];
	logic [31:0]                    mem_data [RESULT_DEPTH];
	logic [PTR_W-1:0]               wr_ptr;
	logic [PTR_W-1:0]               rd_ptr;
	logic [CNT_W-1:0]               count;
	logic                           wr_en;
	logic                           rd_en;

	assign prod_ready = count != FULL;
	assign res_valid  = count != '0;
	assign res_tag    = mem_tag[rd_ptr];
	assign res_data   = mem_data[rd_ptr];

	assign wr_en = prod_valid && prod_ready;
	assign rd_en = res_valid && res_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
			end
			// Simultaneous write and read leave the count alone.
			if (wr_en && !rd_en) begin
				count <= count + 1'b1;
			end else if (rd_en && !wr_en) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem_tag[wr_ptr]  <= prod_tag;
			mem_data[wr_ptr] <= prod_data;
		end
	end

	a_count_bound: assert property (@(posedge clk) disable iff (reset)
		count <= FULL);

endmodule

`default_nettype wire

//--- verilog/fmul_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fmul_unit #(
	parameter int RS_DEPTH     = 2,
	parameter int RESULT_DEPTH = 2
) (
	input  wire                            clk,
	input  wire                            reset,
	input  wire                            issue_valid,
	output logic                           issue_ready,
	input  wire [fmul_pkg::TAG_WIDTH-1:0]  issue_tag,
	input  wire                            opa_ready,
	input  wire [fmul_pkg::TAG_WIDTH-1:0]  opa_tag,
	input  wire [31:0]                     opa_data,
	input  wire                            opb_ready,
	input  wire [fmul_pkg::TAG_WIDTH-1:0]  opb_tag,
	input  wire [31:0]                     opb_data,
	input  wire                            cdb_in_valid,
	input  wire [fmul_pkg::TAG_WIDTH-1:0]  cdb_in_tag,
	input  wire [31:0]                     cdb_in_data,
	output logic                           res_valid,
	input  wire                            res_ready,
	output logic [fmul_pkg::TAG_WIDTH-1:0] res_tag,
	output logic [31:0]                    res_data
);
	logic                           disp_valid;
	logic                           disp_ready;
	logic [fmul_pkg::TAG_WIDTH-1:0] disp_tag;
	logic [31:0]                    disp_a;
	logic [31:0]                    disp_b;

	logic                           prod_valid;
	logic                           prod_ready;
	logic [fmul_pkg::TAG_WIDTH-1:0] prod_tag;
	logic [31:0]                    prod_data;

	fmul_station #(
		.RS_DEPTH(RS_DEPTH)
	) i_station (
		.clk         (clk),
		.reset       (reset),
		.issue_valid (issue_valid),
		.issue_ready (issue_ready),
		.issue_tag   (issue_tag),
		.opa_ready   (opa_ready),
		.opa_tag     (opa_tag),
		.opa_data    (opa_data),
		.opb_ready   (opb_ready),
		.opb_tag     (opb_tag),
		.opb_data    (opb_data),
		.cdb_in_valid(cdb_in_valid),
		.cdb_in_tag  (cdb_in_tag),
		.cdb_in_data (cdb_in_data),
		.disp_valid  (disp_valid),
		.disp_ready  (disp_ready),
		.disp_tag    (disp_tag),
		.disp_a      (disp_a),
		.disp_b      (disp_b)
	);

	fmul_pipe i_pipe (
		.clk       (clk),
		.reset     (reset),
		.disp_valid(disp_valid),
		.disp_ready(disp_ready),
		.disp_tag  (disp_tag),
		.disp_a    (disp_a),
		.disp_b    (disp_b),
		.prod_valid(prod_valid),
		.prod_ready(prod_ready),
		.prod_tag  (prod_tag),
		.prod_data (prod_data)
	);

	fmul_result_buffer #(
		.RESULT_DEPTH(RESULT_DEPTH)
	) i_result_buffer (
		.clk       (clk),
		.reset     (reset),
		.prod_valid(prod_valid),
		.prod_ready(prod_ready),
		.prod_tag  (prod_tag),
		.prod_data (prod_data),
		.res_valid (res_valid),
		.res_ready (res_ready),
		.res_tag   (res_tag),
		.res_data  (res_data)
	);

endmodule

`default_nettype wire

//--- tb/fmul_model.svh
`ifndef FMUL_MODEL_SVH
`define FMUL_MODEL_SVH

localparam int FRAC_W  = fmul_pkg::MAN_WIDTH;
localparam int EXPN_W  = fmul_pkg::EXP_WIDTH;
localparam int BIAS    = (1 << (EXPN_W - 1)) - 1;
localparam int EXP_INF = (1 << EXPN_W) - 1;
localparam int NUM_TAGS = 1 << fmul_pkg::TAG_WIDTH;

// Expected products, one slot per tag in flight.
logic [31:0] sb_value [NUM_TAGS];
bit          sb_pending [NUM_TAGS];
int          sb_count = 0;

// Product with flush-to-zero, round-to-nearest-even and a single NaN.
function automatic logic [31:0] ref_fmul(input logic [31:0] a, input logic [31:0] b);
	logic                  sign;
	int                    ea;
	int                    eb;
	int                    e;
	logic [FRAC_W-1:0]     fa;
	logic [FRAC_W-1:0]     fb;
	logic [2*FRAC_W+1:0]   p;
	logic [FRAC_W+1:0]     r;
	logic                  half;
	logic                  rest;
	sign = a[31] ^ b[31];
	ea = a[FRAC_W +: EXPN_W];
	eb = b[FRAC_W +: EXPN_W];
	fa = a[FRAC_W-1:0];
	fb = b[FRAC_W-1:0];
	if ((ea == EXP_INF && fa != 0) || (eb == EXP_INF && fb != 0))
		return fmul_pkg::CANON_NAN;
	if ((ea == EXP_INF && eb == 0) || (eb == EXP_INF && ea == 0))
		return fmul_pkg::CANON_NAN;
	if (ea == EXP_INF || eb == EXP_INF)
		return {sign, {EXPN_W{1'b1}}, {FRAC_W{1'b0}}};
	if (ea == 0 || eb == 0)
		return {sign, {(EXPN_W + FRAC_W){1'b0}}};
	p = {1'b1, fa} * {1'b1, fb};
	e = ea + eb - BIAS;
	if (p[2*FRAC_W+1])
		e = e + 1;
	else
		p = p << 1;
	half = p[FRAC_W];
	rest = |p[FRAC_W-1:0];
	r = {1'b0, p[2*FRAC_W+1 -: FRAC_W+1]};
	if (half && (rest || r[0]))
		r = r + 1;
	if (r[FRAC_W+1]) begin
		r = r >> 1;
		e = e + 1;
	end
	if (e >= EXP_INF)
		return {sign, {EXPN_W{1'b1}}, {FRAC_W{1'b0}}};
	if (e <= 0)
		return {sign, {(EXPN_W + FRAC_W){1'b0}}};
	return {sign, e[EXPN_W-1:0], r[FRAC_W-1:0]};
endfunction

task automatic expect_result(input logic [fmul_pkg::TAG_WIDTH-1:0] tag, input logic [31:0] value);
	if (sb_pending[tag]) begin
		$display("%s: tag %0d issued again while still in flight", cur_test, tag);
		fail_count++;
	end
	sb_pending[tag] = 1'b1;
	sb_value[tag]   = value;
	sb_count++;
endtask

task automatic check_result(input logic [fmul_pkg::TAG_WIDTH-1:0] tag, input logic [31:0] data);
	if (!sb_pending[tag]) begin
		$display("%s: a result with tag %0d came out but none was expected", cur_test, tag);
		fail_count++;
	end else begin
		if (data !== sb_value[tag]) begin
			$display("[FAIL] %s tag %0d: expected %h, actual %h",
				cur_test, tag, sb_value[tag], data);
			fail_count++;
		end else begin
			pass_count++;
		end
		sb_pending[tag] = 1'b0;
		sb_count--;
	end
endtask

`endif

//--- tb/fmul_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fmul_unit_tb;
	localparam int TAG_W = fmul_pkg::TAG_WIDTH;
	localparam int TOTAL_OPS = 10 + 2 + 12 + 10 + 200;

	logic             clk;
	logic             reset;
	logic             issue_valid;
	logic             issue_ready;
	logic [TAG_W-1:0] issue_tag;
	logic             opa_ready;
	logic [TAG_W-1:0] opa_tag;
	logic [31:0]      opa_data;
	logic             opb_ready;
	logic [TAG_W-1:0] opb_tag;
	logic [31:0]      opb_data;
	logic             cdb_in_valid;
	logic [TAG_W-1:0] cdb_in_tag;
	logic [31:0]      cdb_in_data;
	logic             res_valid;
	logic             res_ready;
	logic [TAG_W-1:0] res_tag;
	logic [31:0]      res_data;

	integer           seed = 32'ha02;
	int               pass_count = 0;
	int               fail_count = 0;
	string            cur_test = "reset";
	logic             rand_ready = 1'b0;
	logic [TAG_W-1:0] seen_tags [$];

	`include "fmul_model.svh"

	fmul_unit #(
		.RS_DEPTH    (2),
		.RESULT_DEPTH(2)
	) i_fmul_unit (
		.clk         (clk),
		.reset       (reset),
		.issue_valid (issue_valid),
		.issue_ready (issue_ready),
		.issue_tag   (issue_tag),
		.opa_ready   (opa_ready),
		.opa_tag     (opa_tag),
		.opa_data    (opa_data),
		.opb_ready   (opb_ready),
		.opb_tag     (opb_tag),
		.opb_data    (opb_data),
		.cdb_in_valid(cdb_in_valid),
		.cdb_in_tag  (cdb_in_tag),
		.cdb_in_data (cdb_in_data),
		.res_valid   (res_valid),
		.res_ready   (res_ready),
		.res_tag     (res_tag),
		.res_data    (res_data)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Handshake is sampled mid-cycle, after all drives have settled.
	always @(negedge clk) begin
		if (!reset && res_valid && res_ready) begin
			seen_tags.push_back(res_tag);
			check_result(res_tag, res_data);
		end
	end

	initial begin
		repeat (TOTAL_OPS * 40) @(posedge clk);
		$display("Watchdog expired before the tests finished");
		$display("Simulation FAILED");
		$finish;
	end

	task automatic next_cycle();
		logic [31:0] rnd;
		@(posedge clk);
		#1;
		if (rand_ready) begin
			rnd = $random(seed);
			res_ready = rnd[0];
		end
	endtask

	function automatic logic [31:0] random_operand();
		logic [31:0] rnd;
		logic [31:0] value;
		rnd = $random(seed);
		value = $random(seed);
		// Mostly moderate exponents; one in four is raw bits.
		if (rnd[1:0] != 2'b00)
			value[30:23] = 8'd96 + {2'b00, value[28:23]};
		return value;
	endfunction

	task automatic issue_op(input logic [TAG_W-1:0] tag,
			input logic ra, input logic [TAG_W-1:0] ta, input logic [31:0] da,
			input logic rb, input logic [TAG_W-1:0] tb, input logic [31:0] db,
			input logic cv, input logic [TAG_W-1:0] ct, input logic [31:0] cd);
		logic accepted;
		issue_valid  = 1'b1;
		issue_tag    = tag;
		opa_ready    = ra;
		opa_tag      = ta;
		opa_data     = da;
		opb_ready    = rb;
		opb_tag      = tb;
		opb_data     = db;
		cdb_in_valid = cv;
		cdb_in_tag   = ct;
		cdb_in_data  = cd;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge clk);
			accepted = issue_ready;
			next_cycle();
		end
		issue_valid  = 1'b0;
		cdb_in_valid = 1'b0;
	endtask

	task automatic issue_both_ready(input logic [TAG_W-1:0] tag, input logic [31:0] a,
			input logic [31:0] b);
		issue_op(tag, 1'b1, '0, a, 1'b1, '0, b, 1'b0, '0, '0);
	endtask

	task automatic broadcast(input logic [TAG_W-1:0] tag, input logic [31:0] data);
		cdb_in_valid = 1'b1;
		cdb_in_tag   = tag;
		cdb_in_data  = data;
		next_cycle();
		cdb_in_valid = 1'b0;
	endtask

	task automatic wait_for_results();
		int cycles;
		cycles = 0;
		while (sb_count != 0 && cycles < 200) begin
			next_cycle();
			cycles++;
		end
		if (sb_count != 0) begin
			$display("%s: %0d results never came out", cur_test, sb_count);
			fail_count++;
		end
	endtask

	task automatic ready_operands_test();
		logic [31:0] a;
		logic [31:0] b;
		cur_test = "ready_operands";
		for (int i = 0; i < 10; i++) begin
			a = random_operand();
			b = random_operand();
			expect_result(TAG_W'(i), ref_fmul(a, b));
			issue_both_ready(TAG_W'(i), a, b);
		end
		wait_for_results();
	endtask

	task automatic wakeup_order_test();
		cur_test = "wakeup_order";
		seen_tags.delete();
		// A waits on tag 3, B on tag 4; stale operand data must not be used.
		expect_result(5'd10, ref_fmul(32'h40a0_0000, 32'h3fc0_0000));
		expect_result(5'd11, ref_fmul(32'h4000_0000, 32'h4040_0000));
		issue_op(5'd10, 1'b0, 5'd3, 32'hdead_beef, 1'b1, '0, 32'h3fc0_0000, 1'b0, '0, '0);
		issue_op(5'd11, 1'b1, '0, 32'h4000_0000, 1'b0, 5'd4, 32'hdead_beef, 1'b0, '0, '0);
		broadcast(5'd4, 32'h4040_0000);
		broadcast(5'd3, 32'h40a0_0000);
		wait_for_results();
		if (seen_tags.size() != 2) begin
			$display("%s: %0d results came out instead of 2", cur_test, seen_tags.size());
			fail_count++;
		end else if (seen_tags[0] != 5'd11) begin
			$display("[FAIL] %s first tag: expected %0d, actual %0d", cur_test, 11, seen_tags[0]);
			fail_count++;
		end
	endtask

	task automatic back_pressure_test();
		logic [31:0] a;
		logic [31:0] b;
		int          n;
		cur_test = "back_pressure";
		res_ready = 1'b0;
		n = 0;
		while (issue_ready && n < 12) begin
			a = random_operand();
			b = random_operand();
			expect_result(TAG_W'(12 + n), ref_fmul(a, b));
			issue_both_ready(TAG_W'(12 + n), a, b);
			n++;
		end
		if (issue_ready) begin
			$display("%s: issue_ready stayed high after %0d issues", cur_test, n);
			fail_count++;
		end
		repeat (4) next_cycle();
		res_ready = 1'b1;
		wait_for_results();
	endtask

	task automatic special_values_test();
		logic [31:0] va [10];
		logic [31:0] vb [10];
		logic [31:0] ve [10];
		cur_test = "special_values";
		va = '{32'h7fc0_0001, 32'h7f80_0000, 32'h7f00_0000, 32'hff00_0000, 32'h0080_0000,
			32'h8080_0000, 32'h0000_0001, 32'hff80_0000, 32'h3f80_0001, 32'h3f80_0003};
		vb = '{32'h3f80_0000, 32'h0000_0000, 32'h7f00_0000, 32'h7f00_0000, 32'h0080_0000,
			32'h0080_0000, 32'h7f7f_ffff, 32'h3f80_0000, 32'h3fc0_0000, 32'h3fc0_0000};
		// Hand-derived products; the last two are ties, one odd and one even.
		ve = '{32'h7fc0_0000, 32'h7fc0_0000, 32'h7f80_0000, 32'hff80_0000, 32'h0000_0000,
			32'h8000_0000, 32'h0000_0000, 32'hff80_0000, 32'h3fc0_0002, 32'h3fc0_0004};
		for (int i = 0; i < 10; i++) begin
			expect_result(TAG_W'(i), ve[i]);
			issue_both_ready(TAG_W'(i), va[i], vb[i]);
		end
		wait_for_results();
	endtask

	task automatic random_stress_test();
		logic [31:0]      a;
		logic [31:0]      b;
		logic [31:0]      rnd;
		logic [TAG_W-1:0] tag;
		logic [TAG_W-1:0] ta;
		logic [TAG_W-1:0] tb;
		logic             wa;
		logic             wb;
		logic             now_a;
		cur_test = "random_stress";
		rand_ready = 1'b1;
		for (int i = 0; i < 200; i++) begin
			tag = TAG_W'(i);
			while (sb_pending[tag])
				next_cycle();
			a = random_operand();
			b = random_operand();
			rnd = $random(seed);
			wa = rnd[0];
			wb = rnd[1];
			now_a = rnd[2];
			ta = rnd[8:4];
			tb = ta ^ 5'h10;
			expect_result(tag, ref_fmul(a, b));
			issue_op(tag, !wa, ta, wa ? $random(seed) : a, !wb, tb, wb ? $random(seed) : b,
				wa && now_a, ta, a);
			if (wa && !now_a)
				broadcast(ta, a);
			if (wb)
				broadcast(tb, b);
			if (rnd[3])
				next_cycle();
		end
		wait_for_results();
		rand_ready = 1'b0;
		res_ready = 1'b1;
	endtask

	task automatic report_test(input int fails_before);
		$display("%s finished with %0d failures", cur_test, fail_count - fails_before);
	endtask

	initial begin
		int fails_before;
		reset        = 1'b1;
		issue_valid  = 1'b0;
		issue_tag    = '0;
		opa_ready    = 1'b0;
		opa_tag      = '0;
		opa_data     = '0;
		opb_ready    = 1'b0;
		opb_tag      = '0;
		opb_data     = '0;
		cdb_in_valid = 1'b0;
		cdb_in_tag   = '0;
		cdb_in_data  = '0;
		res_ready    = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		if (!issue_ready || res_valid) begin
			$display("Outputs after reset are not idle");
			fail_count++;
		end

		fails_before = fail_count;
		ready_operands_test();
		report_test(fails_before);
		fails_before = fail_count;
		wakeup_order_test();
		report_test(fails_before);
		fails_before = fail_count;
		back_pressure_test();
		report_test(fails_before);
		fails_before = fail_count;
		special_values_test();
		report_test(fails_before);
		fails_before = fail_count;
		random_stress_test();
		report_test(fails_before);

		$display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+tb
verilog/fmul_pkg.sv
verilog/fmul_station.sv
verilog/fmul_pipe.sv
verilog/fmul_result_buffer.sv
verilog/fmul_unit.sv
tb/fmul_unit_tb.sv
